// File: include/cache_bridge_config.svh
`ifndef CACHE_BRIDGE_CONFIG_SVH
`define CACHE_BRIDGE_CONFIG_SVH

// width of a data word on both the message and cache sides
`define CB_DATA_WIDTH 64

// width of a byte address
`define CB_ADDR_WIDTH 32

// cache organization
`define CB_BANKS 2
`define CB_SETS 16
`define CB_WAYS 2

// bytes per cache block
`define CB_BLOCK_BYTES 64

// requests that may wait for an answer at once
`define CB_OUTSTANDING 4

`endif

// File: src/cache_bridge_pkg.sv
`include "cache_bridge_config.svh"

package cache_bridge_pkg;

  localparam int data_bytes_gp = `CB_DATA_WIDTH / 8;
  localparam int lg_banks_gp = (`CB_BANKS > 1) ? $clog2(`CB_BANKS) : 1;
  localparam int block_offset_width_gp = $clog2(`CB_BLOCK_BYTES);

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } msg_type_e;

  // log2 of the access size in bytes
  typedef enum logic [2:0]
  {
    e_size_1 = 3'd0,
    e_size_2 = 3'd1,
    e_size_4 = 3'd2,
    e_size_8 = 3'd3
  } msg_size_e;

  typedef struct packed
  {
    msg_type_e msg_type;
    msg_size_e size;
    logic [`CB_ADDR_WIDTH-1:0] addr;
    logic [3:0] tag;
  } mem_hdr_t;

  typedef enum logic [3:0]
  {
    e_lb = 4'd0,
    e_lh = 4'd1,
    e_lw = 4'd2,
    e_ld = 4'd3,
    e_sb = 4'd4,
    e_sh = 4'd5,
    e_sw = 4'd6,
    e_sd = 4'd7,
    e_tagst = 4'd8
  } cache_op_e;

  // one mask bit per data byte
  typedef struct packed
  {
    cache_op_e opcode;
    logic [`CB_ADDR_WIDTH-1:0] addr;
    logic [`CB_DATA_WIDTH-1:0] data;
    logic [data_bytes_gp-1:0] mask;
  } cache_pkt_t;

  typedef logic [lg_banks_gp-1:0] bank_t;

  typedef struct packed
  {
    bank_t bank;
    mem_hdr_t hdr;
  } pending_t;

  // bank index sits right above the block offset
  function automatic bank_t addr_to_bank(input logic [`CB_ADDR_WIDTH-1:0] addr);
    return addr[block_offset_width_gp +: lg_banks_gp];
  endfunction

endpackage

// File: src/tag_clear_seq.sv
`include "cache_bridge_config.svh"

module tag_clear_seq
  (input logic clk_i
   , input logic reset_i
   , output cache_bridge_pkg::cache_pkt_t pkt_o
   , output logic [`CB_BANKS-1:0] pkt_v_o
   , input logic [`CB_BANKS-1:0] pkt_ready_i
   , input logic [`CB_BANKS-1:0] ack_v_i
   , output logic [`CB_BANKS-1:0] ack_yumi_o
   , output logic done_o
   );

  import cache_bridge_pkg::*;

  localparam int lines_per_bank_lp = `CB_SETS * `CB_WAYS;
  localparam int total_lines_lp = `CB_BANKS * lines_per_bank_lp;
  localparam int line_idx_width_lp = (lines_per_bank_lp > 1) ? $clog2(lines_per_bank_lp) : 1;
  localparam int cnt_width_lp = $clog2(total_lines_lp + 1);
  localparam logic [cnt_width_lp-1:0] total_cnt_lp = cnt_width_lp'(total_lines_lp);

  typedef enum logic [1:0] {e_reset, e_clear, e_done} state_e;

  state_e state_r, state_n;
  logic [cnt_width_lp-1:0] sent_r, sent_n;
  logic [cnt_width_lp-1:0] recv_r, recv_n;
  bank_t sent_bank;
  logic [`CB_ADDR_WIDTH-1:0] line_addr;

  // lines are walked bank by bank with the set and way index in the low bits
  assign sent_bank = bank_t'(sent_r / lines_per_bank_lp);
  assign line_addr = `CB_ADDR_WIDTH'(sent_r[line_idx_width_lp-1:0]) << block_offset_width_gp;

  always_comb
  begin
    pkt_o = '0;
    pkt_o.opcode = e_tagst;
    pkt_o.addr = line_addr;
  end

  always_comb
  begin
    pkt_v_o = '0;
    ack_yumi_o = '0;
    sent_n = sent_r;
    recv_n = recv_r;
    state_n = state_r;
    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        if (sent_r != total_cnt_lp)
          pkt_v_o[sent_bank] = 1'b1;
        // answers from several banks may land together
        ack_yumi_o = ack_v_i;
        if (|(pkt_v_o & pkt_ready_i))
          sent_n = sent_r + 1'b1;
        recv_n = recv_r + cnt_width_lp'($countones(ack_yumi_o));
        if ((sent_n == total_cnt_lp) && (recv_n == total_cnt_lp))
          state_n = e_done;
      end
      default:
        state_n = e_done;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      sent_r <= '0;
      recv_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      sent_r <= sent_n;
      recv_r <= recv_n;
    end
  end

  assign done_o = (state_r == e_done);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    (sent_r <= total_cnt_lp) && (recv_r <= total_cnt_lp));

  // a bank only answers a TAGST it has already taken
  a_ack_after_send: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_clear) |-> (recv_n <= sent_n));

endmodule

// File: src/fwd_decode.sv
`include "cache_bridge_config.svh"

module fwd_decode
  (input cache_bridge_pkg::mem_hdr_t hdr_i
   , input logic [`CB_DATA_WIDTH-1:0] data_i
   , output cache_bridge_pkg::cache_pkt_t pkt_o
   , output cache_bridge_pkg::bank_t bank_o
   );

  import cache_bridge_pkg::*;

  localparam int byte_offset_width_lp = $clog2(data_bytes_gp);

  cache_op_e load_op;
  cache_op_e store_op;
  logic is_store;
  logic [byte_offset_width_lp-1:0] byte_offset;
  logic [data_bytes_gp-1:0] byte_mask;

  assign is_store = (hdr_i.msg_type == e_mem_wr);
  assign byte_offset = hdr_i.addr[byte_offset_width_lp-1:0];

  // opcode pair for each access size
  always_comb
  begin
    case (hdr_i.size)
      e_size_1:
      begin
        load_op = e_lb;
        store_op = e_sb;
      end
      e_size_2:
      begin
        load_op = e_lh;
        store_op = e_sh;
      end
      e_size_4:
      begin
        load_op = e_lw;
        store_op = e_sw;
      end
      e_size_8:
      begin
        load_op = e_ld;
        store_op = e_sd;
      end
      default:
      begin
        load_op = e_ld;
        store_op = e_sd;
      end
    endcase
  end

  // a byte is enabled when it lies in the same size-aligned chunk as the address
  always_comb
  begin
    for (int i = 0; i < data_bytes_gp; i++)
    begin
      byte_mask[i] = ((i >> hdr_i.size) == (int'(byte_offset) >> hdr_i.size));
    end
  end

  always_comb
  begin
    pkt_o = '0;
    if (is_store)
      pkt_o.opcode = store_op;
    else
      pkt_o.opcode = load_op;
    pkt_o.addr = hdr_i.addr;
    pkt_o.data = data_i;
    pkt_o.mask = byte_mask;
  end

  assign bank_o = addr_to_bank(hdr_i.addr);

  // only single-beat accesses up to one data word reach the bridge
  always_comb
  begin
    a_size_range: assert ($isunknown(hdr_i.size) || (hdr_i.size <= e_size_8))
      else $error("fwd_decode: access size %0d is wider than a data word", hdr_i.size);
  end

endmodule

// File: src/resp_order_fifo.sv
`include "cache_bridge_config.svh"

module resp_order_fifo
  (input logic clk_i
   , input logic reset_i
   , input logic push_i
   , input cache_bridge_pkg::pending_t push_data_i
   , output logic full_o
   , input logic pop_i
   , output cache_bridge_pkg::pending_t head_o
   , output logic head_v_o
   );

  import cache_bridge_pkg::*;

  localparam int depth_lp = `CB_OUTSTANDING;
  localparam int ptr_width_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_width_lp = $clog2(depth_lp + 1);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(depth_lp - 1);

  pending_t mem_r [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;

  // wrap also works for depths that are not a power of two
  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == last_ptr_lp) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= push_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      if (pop_i)
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      case ({push_i, pop_i})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  assign full_o = (count_r == cnt_width_lp'(depth_lp));
  assign head_v_o = (count_r != '0);
  assign head_o = mem_r[rd_ptr_r];

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> head_v_o);

endmodule

// File: src/rev_pack.sv
`include "cache_bridge_config.svh"

module rev_pack
  (input cache_bridge_pkg::pending_t entry_i
   , input logic entry_v_i
   , input logic [`CB_BANKS-1:0][`CB_DATA_WIDTH-1:0] cache_data_i
   , input logic [`CB_BANKS-1:0] cache_data_v_i
   , output cache_bridge_pkg::mem_hdr_t rev_hdr_o
   , output logic [`CB_DATA_WIDTH-1:0] rev_data_o
   , output logic rev_v_o
   );

  import cache_bridge_pkg::*;

  logic [`CB_DATA_WIDTH-1:0] bank_word;
  logic bank_v;
  msg_size_e resp_size;

  // answer of the bank that owns the oldest request
  assign bank_word = cache_data_i[entry_i.bank];
  assign bank_v = cache_data_v_i[entry_i.bank];
  assign resp_size = entry_i.hdr.size;

  // the cache returns B/H/W/D results at the low end of the word
  always_comb
  begin
    rev_data_o = bank_word;
    for (int i = 0; i < data_bytes_gp; i++)
    begin
      if ((i >> resp_size) != 0)
        rev_data_o[8*i +: 8] = 8'h00;
    end
  end

  assign rev_hdr_o = entry_i.hdr;

  // stores also wait for their answer so ordering stays intact
  assign rev_v_o = entry_v_i & bank_v;

endmodule

// File: src/cache_bridge_top.sv
`include "cache_bridge_config.svh"

module cache_bridge_top
  (input logic clk_i
   , input logic reset_i

   , input cache_bridge_pkg::mem_hdr_t mem_fwd_hdr_i
   , input logic [`CB_DATA_WIDTH-1:0] mem_fwd_data_i
   , input logic mem_fwd_v_i
   , output logic mem_fwd_ready_o

   , output cache_bridge_pkg::mem_hdr_t mem_rev_hdr_o
   , output logic [`CB_DATA_WIDTH-1:0] mem_rev_data_o
   , output logic mem_rev_v_o
   , input logic mem_rev_ready_i

   // the packet is shared while valid and ready are per bank
   , output cache_bridge_pkg::cache_pkt_t cache_pkt_o
   , output logic [`CB_BANKS-1:0] cache_pkt_v_o
   , input logic [`CB_BANKS-1:0] cache_pkt_ready_i

   , input logic [`CB_BANKS-1:0][`CB_DATA_WIDTH-1:0] cache_data_i
   , input logic [`CB_BANKS-1:0] cache_data_v_i
   , output logic [`CB_BANKS-1:0] cache_data_yumi_o
   );

  localparam logic [`CB_BANKS-1:0] bank_one_lp = `CB_BANKS'(1);

  cache_bridge_pkg::cache_pkt_t clear_pkt;
  logic [`CB_BANKS-1:0] clear_pkt_v;
  logic [`CB_BANKS-1:0] clear_yumi;
  logic clear_done;

  cache_bridge_pkg::cache_pkt_t req_pkt;
  cache_bridge_pkg::bank_t req_bank;
  cache_bridge_pkg::pending_t push_entry;
  cache_bridge_pkg::pending_t head_entry;
  logic fifo_full;
  logic head_v;
  logic req_v;
  logic fwd_fire;
  logic rev_fire;

  tag_clear_seq clear_seq
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.pkt_o(clear_pkt)
     ,.pkt_v_o(clear_pkt_v)
     ,.pkt_ready_i(cache_pkt_ready_i)
     ,.ack_v_i(cache_data_v_i)
     ,.ack_yumi_o(clear_yumi)
     ,.done_o(clear_done)
     );

  fwd_decode decode
    (.hdr_i(mem_fwd_hdr_i)
     ,.data_i(mem_fwd_data_i)
     ,.pkt_o(req_pkt)
     ,.bank_o(req_bank)
     );

  // a request goes out only when its answer has a queue slot
  assign req_v = clear_done & mem_fwd_v_i & ~fifo_full;
  assign mem_fwd_ready_o = clear_done & ~fifo_full & cache_pkt_ready_i[req_bank];
  assign fwd_fire = mem_fwd_v_i & mem_fwd_ready_o;

  assign cache_pkt_o = clear_done ? req_pkt : clear_pkt;
  assign cache_pkt_v_o = clear_done ? (req_v ? (bank_one_lp << req_bank) : '0) : clear_pkt_v;

  assign push_entry.bank = req_bank;
  assign push_entry.hdr = mem_fwd_hdr_i;

  resp_order_fifo order_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.push_i(fwd_fire)
     ,.push_data_i(push_entry)
     ,.full_o(fifo_full)
     ,.pop_i(rev_fire)
     ,.head_o(head_entry)
     ,.head_v_o(head_v)
     );

  rev_pack rev
    (.entry_i(head_entry)
     ,.entry_v_i(head_v)
     ,.cache_data_i(cache_data_i)
     ,.cache_data_v_i(cache_data_v_i)
     ,.rev_hdr_o(mem_rev_hdr_o)
     ,.rev_data_o(mem_rev_data_o)
     ,.rev_v_o(mem_rev_v_o)
     );

  assign rev_fire = mem_rev_v_o & mem_rev_ready_i;

  // the answer stays in its bank until the response is taken
  assign cache_data_yumi_o = clear_done
    ? (rev_fire ? (bank_one_lp << head_entry.bank) : '0)
    : clear_yumi;

  // a response that is not taken stays valid until it is
  a_rev_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_rev_v_o && !mem_rev_ready_i) |=> mem_rev_v_o);

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen
  (output logic clk_o
   , output logic reset_o
   );

  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial
  begin
    clk_o = 1'b0;
    forever
      #20 clk_o = ~clk_o;
  end

  // reset spans four rising edges, released just after the last one
  initial
  begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// File: tests/tb_cache_bridge.sv
`include "cache_bridge_config.svh"

module tb_cache_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_bridge_pkg::*;

  localparam int lines_per_bank_lp = `CB_SETS * `CB_WAYS;
  localparam int total_lines_lp = `CB_BANKS * lines_per_bank_lp;
  localparam int block_lg_lp = $clog2(`CB_BLOCK_BYTES);
  localparam int window_lp = 512;
  localparam int num_resp_lp = 400;
  localparam int stall_limit_lp = 1000;
  localparam int reset_limit_lp = 20;

  logic clk;
  logic reset;

  mem_hdr_t fwd_hdr;
  logic [`CB_DATA_WIDTH-1:0] fwd_data;
  logic fwd_v;
  logic fwd_ready;
  mem_hdr_t rev_hdr;
  logic [`CB_DATA_WIDTH-1:0] rev_data;
  logic rev_v;
  logic rev_ready;
  cache_pkt_t pkt;
  logic [`CB_BANKS-1:0] pkt_v;
  logic [`CB_BANKS-1:0] pkt_ready;
  logic [`CB_BANKS-1:0][`CB_DATA_WIDTH-1:0] cdata;
  logic [`CB_BANKS-1:0] cdata_v;
  logic [`CB_BANKS-1:0] cdata_yumi;

  logic [31:0] lfsr_r;
  logic [7:0] mem [window_lp];
  logic [`CB_DATA_WIDTH-1:0] answer_q [`CB_BANKS][$];
  int wait_cnt [`CB_BANKS];
  mem_hdr_t exp_hdr_q [$];
  logic [`CB_DATA_WIDTH-1:0] exp_data_q [$];
  bit seen [`CB_BANKS][lines_per_bank_lp];
  int tagst_sent;
  int acks_seen;
  int resp_cnt;
  int stall_cnt;
  logic fwd_held;

  tb_clock_gen clock_gen
    (.clk_o(clk)
     ,.reset_o(reset)
     );

  cache_bridge_top uut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.mem_fwd_hdr_i(fwd_hdr)
     ,.mem_fwd_data_i(fwd_data)
     ,.mem_fwd_v_i(fwd_v)
     ,.mem_fwd_ready_o(fwd_ready)
     ,.mem_rev_hdr_o(rev_hdr)
     ,.mem_rev_data_o(rev_data)
     ,.mem_rev_v_o(rev_v)
     ,.mem_rev_ready_i(rev_ready)
     ,.cache_pkt_o(pkt)
     ,.cache_pkt_v_o(pkt_v)
     ,.cache_pkt_ready_i(pkt_ready)
     ,.cache_data_i(cdata)
     ,.cache_data_v_i(cdata_v)
     ,.cache_data_yumi_o(cdata_yumi)
     );

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      v = {v[30:0], lfsr_r[0]};
    end
    return v;
  endfunction

  // bytes at or above n come back as zero
  function automatic logic [`CB_DATA_WIDTH-1:0] read_bytes(input int addr, input int n);
    logic [`CB_DATA_WIDTH-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v[8*i +: 8] = mem[(addr + i) % window_lp];
    return v;
  endfunction

  function automatic cache_op_e expected_op(input mem_hdr_t h);
    logic wr;
    wr = (h.msg_type == e_mem_wr);
    case (h.size)
      e_size_1: return wr ? e_sb : e_lb;
      e_size_2: return wr ? e_sh : e_lh;
      e_size_4: return wr ? e_sw : e_lw;
      default: return wr ? e_sd : e_ld;
    endcase
  endfunction

  function automatic int op_bytes(input cache_op_e op);
    case (op)
      e_lb, e_sb: return 1;
      e_lh, e_sh: return 2;
      e_lw, e_sw: return 4;
      default: return 8;
    endcase
  endfunction

  task automatic drive_inputs();
    int size;
    for (int b = 0; b < `CB_BANKS; b++)
    begin
      pkt_ready[b] = (take_bits(2) != 0);
      cdata_v[b] = (answer_q[b].size() != 0) && (wait_cnt[b] == 0);
      cdata[b] = (answer_q[b].size() != 0) ? answer_q[b][0] : '0;
    end
    rev_ready = (take_bits(2) != 0);
    // a stalled request keeps its header until it is taken
    if (!fwd_held)
    begin
      size = int'(take_bits(2));
      fwd_hdr.msg_type = take_bits(1) ? e_mem_wr : e_mem_rd;
      fwd_hdr.size = msg_size_e'(size);
      fwd_hdr.addr = `CB_ADDR_WIDTH'(take_bits(9));
      fwd_hdr.tag = 4'(take_bits(4));
      fwd_data = {take_bits(32), take_bits(32)};
      fwd_v = (take_bits(2) != 0);
    end
  endtask

  task automatic check_tagst(input int b);
    int idx;
    idx = int'(pkt.addr >> block_lg_lp);
    check_value("cache_pkt_o.opcode", pkt.opcode, e_tagst);
    check_value("cache_pkt_o.data", pkt.data, 0);
    check_value("cache_pkt_o.mask", pkt.mask, 0);
    if ((idx >= lines_per_bank_lp) || seen[b][idx])
    begin
      $display("TAGST line %0d on bank %0d is out of range or repeated", idx, b);
      abort_run();
    end
    seen[b][idx] = 1'b1;
    tagst_sent++;
  endtask

  task automatic check_request(input logic fwd_fire);
    int size;
    int offset;
    int b_exp;
    logic [data_bytes_gp-1:0] mask_exp;
    if (!fwd_fire)
    begin
      $display("a bank took a cache packet without a forward transfer");
      abort_run();
    end
    size = 1 << int'(fwd_hdr.size);
    b_exp = int'(fwd_hdr.addr >> block_lg_lp) % `CB_BANKS;
    // the mask starts at the address offset rounded down to the access size
    offset = ((int'(fwd_hdr.addr) % data_bytes_gp) / size) * size;
    mask_exp = data_bytes_gp'((1 << size) - 1) << offset;
    check_value("cache_pkt_v_o", pkt_v, 128'(1) << b_exp);
    check_value("cache_pkt_o.opcode", pkt.opcode, expected_op(fwd_hdr));
    check_value("cache_pkt_o.addr", pkt.addr, fwd_hdr.addr);
    check_value("cache_pkt_o.mask", pkt.mask, mask_exp);
    if (fwd_hdr.msg_type == e_mem_wr)
    begin
      check_value("cache_pkt_o.data", pkt.data, fwd_data);
      exp_data_q.push_back('0);
    end
    else
      exp_data_q.push_back(read_bytes(int'(fwd_hdr.addr), size));
    exp_hdr_q.push_back(fwd_hdr);
    check_value("requests in flight within limit",
                exp_hdr_q.size() <= `CB_OUTSTANDING, 1);
  endtask

  // the bank model fixes each answer when it takes the packet
  task automatic bank_accept(input int b);
    int addr;
    addr = int'(pkt.addr);
    case (pkt.opcode)
      e_tagst:
        answer_q[b].push_back('0);
      e_sb, e_sh, e_sw, e_sd:
      begin
        for (int i = 0; i < op_bytes(pkt.opcode); i++)
          mem[(addr + i) % window_lp] = pkt.data[8*i +: 8];
        answer_q[b].push_back('0);
      end
      // upper bytes carry neighbours so trimming is exercised
      default:
        answer_q[b].push_back(read_bytes(addr, data_bytes_gp));
    endcase
  endtask

  task automatic observe_cycle();
    logic fwd_fire;
    logic rev_fire;
    fwd_fire = fwd_v && fwd_ready;
    rev_fire = rev_v && rev_ready;
    if (fwd_ready)
      check_value("clear answers before mem_fwd_ready_o", acks_seen >= total_lines_lp, 1);
    check_value("cache_data_yumi_o without valid", cdata_yumi & ~cdata_v, 0);

    if (rev_fire)
    begin
      if (exp_hdr_q.size() == 0)
      begin
        $display("a response came back with no request outstanding");
        abort_run();
      end
      check_value("mem_rev_hdr_o", rev_hdr, exp_hdr_q.pop_front());
      check_value("mem_rev_data_o", rev_data, exp_data_q.pop_front());
      resp_cnt++;
      stall_cnt = 0;
    end

    for (int b = 0; b < `CB_BANKS; b++)
    begin
      if (wait_cnt[b] > 0)
        wait_cnt[b]--;
      if (cdata_yumi[b])
      begin
        void'(answer_q[b].pop_front());
        wait_cnt[b] = int'(take_bits(2));
        acks_seen++;
      end
    end

    for (int b = 0; b < `CB_BANKS; b++)
    begin
      if (pkt_v[b] && pkt_ready[b])
      begin
        stall_cnt = 0;
        if (tagst_sent < total_lines_lp)
          check_tagst(b);
        else
          check_request(fwd_fire);
        bank_accept(b);
      end
    end
    if (fwd_fire && !(|(pkt_v & pkt_ready)))
    begin
      $display("a forward request was accepted but no bank took its packet");
      abort_run();
    end
    fwd_held = fwd_v && !fwd_fire;
  endtask

  initial
  begin
    int wait_cycles;
    lfsr_r = 32'hb2c727c2;
    fwd_hdr = '0;
    fwd_data = '0;
    fwd_v = 1'b0;
    rev_ready = 1'b0;
    pkt_ready = '0;
    cdata = '0;
    cdata_v = '0;
    fwd_held = 1'b0;
    tagst_sent = 0;
    acks_seen = 0;
    resp_cnt = 0;
    stall_cnt = 0;
    for (int b = 0; b < `CB_BANKS; b++)
      wait_cnt[b] = 0;
    for (int i = 0; i < window_lp; i++)
      mem[i] = 8'(i * 29) ^ 8'(i >> 3);

    wait_cycles = 0;
    // the first rising edge applies reset before any output is looked at
    @(posedge clk);
    @(negedge clk);
    while (reset && (wait_cycles < reset_limit_lp))
    begin
      check_value("outputs low in reset", {pkt_v, fwd_ready, rev_v, cdata_yumi}, 0);
      @(negedge clk);
      wait_cycles++;
    end
    if (reset)
    begin
      $display("reset was never released");
      abort_run();
    end

    while (resp_cnt < num_resp_lp)
    begin
      @(posedge clk);
      #2;
      drive_inputs();
      @(negedge clk);
      observe_cycle();
      stall_cnt++;
      if (stall_cnt > stall_limit_lp)
      begin
        $display("no cache packet and no response for %0d cycles, %0d responses seen",
                 stall_limit_lp, resp_cnt);
        abort_run();
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
src/cache_bridge_pkg.sv
src/tag_clear_seq.sv
src/fwd_decode.sv
src/resp_order_fifo.sv
src/rev_pack.sv
src/cache_bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_cache_bridge.sv

// File: Makefile
# Verilator build and run for the cache bridge testbench
# any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP ?= tb_cache_bridge
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= ALL CHECKS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
